/* hw/clkgen_lock_mon.sv */
// lock monitor in the control clock domain
// two flop sync of lock flags, sticky lost lock, output reset release
`timescale 1ns/100ps
`default_nettype none

module clkgen_lock_mon (
   input  wire   clk,
   input  wire   reset,
   input  wire   en,         // registered pll enable
   input  wire   freqlock,   // async
   input  wire   phaselock,  // async
   input  wire   clr_lost,   // status write pulse
   output logic  lock_sync,
   output logic  lock_lost,
   output logic  out_reset
);

   logic                                freq_meta;
   logic                                freq_sync;
   logic                                phase_meta;
   logic                                phase_sync;
   logic                                lock_sync_q;
   logic                                lock_fall;
   logic [clkgen_pkg::HOLD_CNTW-1:0]    hold_cnt;

   //##################################################
   // synchronisers
   //##################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         freq_meta  <= 1'b0;
         freq_sync  <= 1'b0;
         phase_meta <= 1'b0;
         phase_sync <= 1'b0;
      end else begin
         freq_meta  <= freqlock;
         freq_sync  <= freq_meta;
         phase_meta <= phaselock;
         phase_sync <= phase_meta;
      end
   end

   assign lock_sync = freq_sync & phase_sync;  // both flags needed

   // sticky lost lock
   assign lock_fall = lock_sync_q & ~lock_sync;

   always_ff @(posedge clk) begin
      if (reset) begin
         lock_sync_q <= 1'b0;
         lock_lost   <= 1'b0;
      end else begin
         lock_sync_q <= lock_sync;
         if (lock_fall && en)
            lock_lost <= 1'b1;  // new loss wins over clear
         else if (clr_lost || !en)
            lock_lost <= 1'b0;
      end
   end

   //##################################################
   // output domain reset
   //##################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         hold_cnt  <= '0;
         out_reset <= 1'b1;
      end else if (!lock_sync) begin
         hold_cnt  <= '0;
         out_reset <= 1'b1;  // reassert one cycle after loss
      end else if (hold_cnt == clkgen_pkg::HOLD_LAST) begin
         out_reset <= 1'b0;  // RST_HOLD cycles of stable lock
      end else begin
         hold_cnt <= hold_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hw/clkgen_pkg.sv */
// shared widths, register map and lock constants for the clock generator
// cfg_word_u union gives control and divider views of one data word
`default_nettype none

package clkgen_pkg;

   //##################################################
   // widths and counts
   //##################################################
   localparam int NIN   = 2;   // reference clocks
   localparam int NOUT  = 2;   // output clocks
   localparam int DIVW  = 8;   // divider and phase field width
   localparam int DATAW = 32;  // register data word
   localparam int ADDRW = 3;   // register address

   // register map
   localparam logic [ADDRW-1:0] ADDR_CTRL   = 3'd0;
   localparam logic [ADDRW-1:0] ADDR_DIV    = 3'd1;  // divin, divfb, divfrac
   localparam logic [ADDRW-1:0] ADDR_DIVOUT = 3'd2;  // divout for both outputs
   localparam logic [ADDRW-1:0] ADDR_PHASE  = 3'd3;
   localparam logic [ADDRW-1:0] ADDR_STATUS = 3'd4;  // write clears lost flag

   localparam logic [NIN-1:0] CLKSEL_DEF = 2'b01;  // input 0, also reset value

   //##################################################
   // lock model and output reset timing
   //##################################################
   localparam int LOCK_EDGES  = 16;  // ref edges to freqlock
   localparam int PHASE_EDGES = 8;   // further edges to phaselock
   localparam int RST_HOLD    = 4;   // clk cycles from lock to reset release

   localparam int LOCK_CNTW = $clog2(LOCK_EDGES + PHASE_EDGES + 1);
   localparam logic [LOCK_CNTW-1:0] FREQ_CNT  = LOCK_CNTW'(LOCK_EDGES);
   localparam logic [LOCK_CNTW-1:0] PHASE_CNT = LOCK_CNTW'(LOCK_EDGES + PHASE_EDGES);

   localparam int HOLD_CNTW = $clog2(RST_HOLD + 1);
   localparam logic [HOLD_CNTW-1:0] HOLD_LAST = HOLD_CNTW'(RST_HOLD - 1);

   // two decodes of one write word
   typedef struct packed {
      logic [DATAW-NIN-3:0] rsvd;
      logic [NIN-1:0]       clksel;  // one hot
      logic                 bypass;
      logic                 en;
   } ctrl_view_t;

   typedef struct packed {
      logic [DATAW-3*DIVW-1:0] spare;
      logic [DIVW-1:0]         divfrac;
      logic [DIVW-1:0]         divfb;
      logic [DIVW-1:0]         divin;
   } div_view_t;

   typedef union packed {
      ctrl_view_t ctrl;
      div_view_t  div;
   } cfg_word_u;

endpackage

`default_nettype wire

/* hw/clkgen_regs.sv */
// control register bank for the clock generator
// single cycle write, registered read, status readback
`timescale 1ns/100ps
`default_nettype none

module clkgen_regs (
   input  wire                                           clk,
   input  wire                                           reset,
   // register access
   input  wire                                           wr,
   input  wire                                           rd,
   input  wire  [clkgen_pkg::ADDRW-1:0]                  addr,
   input  wire  [clkgen_pkg::DATAW-1:0]                  wdata,
   output logic [clkgen_pkg::DATAW-1:0]                  rdata,
   // status from lock monitor
   input  wire                                           lock_sync,
   input  wire                                           lock_lost,
   output logic                                          clr_lost,
   // pll controls
   output logic                                          en,
   output logic                                          bypass,
   output logic [clkgen_pkg::NIN-1:0]                    clksel,
   output logic [clkgen_pkg::DIVW-1:0]                   divin,
   output logic [clkgen_pkg::DIVW-1:0]                   divfb,
   output logic [clkgen_pkg::DIVW-1:0]                   divfrac,
   output logic [clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0]  divout,
   output logic [clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0]  phase
);

   clkgen_pkg::cfg_word_u          wcfg;     // incoming word, two views
   clkgen_pkg::cfg_word_u          ctrl_rd;  // readback of ctrl
   clkgen_pkg::cfg_word_u          div_rd;   // readback of dividers
   logic [clkgen_pkg::DATAW-1:0]   rd_word;
   logic [clkgen_pkg::NIN-1:0]     sel_wr;

   assign wcfg = wdata;

   // non one-hot select falls back to input 0
   assign sel_wr = $onehot(wcfg.ctrl.clksel) ? wcfg.ctrl.clksel : clkgen_pkg::CLKSEL_DEF;

   assign clr_lost = wr && (addr == clkgen_pkg::ADDR_STATUS);  // one cycle pulse

   //##################################################
   // write side
   //##################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         en     <= 1'b0;
         bypass <= 1'b0;
         clksel <= clkgen_pkg::CLKSEL_DEF;
      end else if (wr && (addr == clkgen_pkg::ADDR_CTRL)) begin
         en     <= wcfg.ctrl.en;
         bypass <= wcfg.ctrl.bypass;
         clksel <= sel_wr;
      end
   end

   // divider and phase words, payload only
   always_ff @(posedge clk) begin
      if (wr) begin
         case (addr)
            clkgen_pkg::ADDR_DIV: begin
               divin   <= wcfg.div.divin;
               divfb   <= wcfg.div.divfb;
               divfrac <= wcfg.div.divfrac;
            end
            clkgen_pkg::ADDR_DIVOUT: divout <= wdata[clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0];
            clkgen_pkg::ADDR_PHASE:  phase  <= wdata[clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0];
            default: ;  // ctrl and status handled elsewhere
         endcase
      end
   end

   //##################################################
   // read side
   //##################################################
   always_comb begin
      ctrl_rd             = '0;
      ctrl_rd.ctrl.en     = en;
      ctrl_rd.ctrl.bypass = bypass;
      ctrl_rd.ctrl.clksel = clksel;
      div_rd              = '0;
      div_rd.div.divin    = divin;
      div_rd.div.divfb    = divfb;
      div_rd.div.divfrac  = divfrac;
      rd_word             = '0;
      case (addr)
         clkgen_pkg::ADDR_CTRL:   rd_word = ctrl_rd;
         clkgen_pkg::ADDR_DIV:    rd_word = div_rd;
         clkgen_pkg::ADDR_DIVOUT: rd_word[clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0] = divout;
         clkgen_pkg::ADDR_PHASE:  rd_word[clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0] = phase;
         clkgen_pkg::ADDR_STATUS: rd_word[1:0] = {lock_lost, lock_sync};  // bit0 lock
         default: ;  // unmapped reads zero
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         rdata <= '0;
      else if (rd)
         rdata <= rd_word;  // held until next read
   end

endmodule

`default_nettype wire

/* hw/clkgen_top.sv */
// clock generator top level
// register bank, behavioural pll and lock monitor
`timescale 1ns/100ps
`default_nettype none

module clkgen_top (
   input  wire                           clk,
   input  wire                           reset,
   input  wire  [clkgen_pkg::NIN-1:0]    clkin,
   // register access
   input  wire                           wr,
   input  wire                           rd,
   input  wire  [clkgen_pkg::ADDRW-1:0]  addr,
   input  wire  [clkgen_pkg::DATAW-1:0]  wdata,
   output logic [clkgen_pkg::DATAW-1:0]  rdata,
   // generated clocks
   output logic [clkgen_pkg::NOUT-1:0]   clkout,
   output logic                          clkvco,
   output logic                          out_reset  // sync reset for clkout users
);

   logic                                           en;
   logic                                           bypass;
   logic [clkgen_pkg::NIN-1:0]                     clksel;
   logic [clkgen_pkg::DIVW-1:0]                    divin;
   logic [clkgen_pkg::DIVW-1:0]                    divfb;
   logic [clkgen_pkg::DIVW-1:0]                    divfrac;
   logic [clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0]   divout;
   logic [clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0]   phase;
   logic                                           freqlock;   // async to clk
   logic                                           phaselock;  // async to clk
   logic                                           lock_sync;
   logic                                           lock_lost;
   logic                                           clr_lost;

   clkgen_regs u_regs (
      .clk       (clk),
      .reset     (reset),
      .wr        (wr),
      .rd        (rd),
      .addr      (addr),
      .wdata     (wdata),
      .rdata     (rdata),
      .lock_sync (lock_sync),
      .lock_lost (lock_lost),
      .clr_lost  (clr_lost),
      .en        (en),
      .bypass    (bypass),
      .clksel    (clksel),
      .divin     (divin),
      .divfb     (divfb),
      .divfrac   (divfrac),
      .divout    (divout),
      .phase     (phase)
   );

   la_pll u_pll (
      .clkin     (clkin),
      .clkfbin   (1'b0),   // no external feedback
      .reset     (reset),
      .en        (en),
      .bypass    (bypass),
      .clksel    (clksel),
      .divin     (divin),
      .divfb     (divfb),
      .divfrac   (divfrac),
      .divout    (divout),
      .phase     (phase),
      .clkout    (clkout),
      .clkfbout  (),
      .clkvco    (clkvco),
      .freqlock  (freqlock),
      .phaselock (phaselock)
   );

   clkgen_lock_mon u_lock_mon (
      .clk       (clk),
      .reset     (reset),
      .en        (en),
      .freqlock  (freqlock),
      .phaselock (phaselock),
      .clr_lost  (clr_lost),
      .lock_sync (lock_sync),
      .lock_lost (lock_lost),
      .out_reset (out_reset)
   );

endmodule

`default_nettype wire

/* hw/la_pll.sv */
// behavioural pll model, safe for verilator
// ref clock mux, enable gating, per output bypass, edge counting lock
`timescale 1ns/100ps
`default_nettype none

module la_pll (
   // clocks
   input  wire  [clkgen_pkg::NIN-1:0]                    clkin,     // reference clocks
   input  wire                                           clkfbin,   // ext feedback, not modelled
   output logic [clkgen_pkg::NOUT-1:0]                   clkout,
   output logic                                          clkfbout,
   output logic                                          clkvco,
   // controls
   input  wire                                           reset,
   input  wire                                           en,
   input  wire                                           bypass,
   input  wire  [clkgen_pkg::NIN-1:0]                    clksel,    // one hot
   input  wire  [clkgen_pkg::DIVW-1:0]                   divin,
   input  wire  [clkgen_pkg::DIVW-1:0]                   divfb,
   input  wire  [clkgen_pkg::DIVW-1:0]                   divfrac,
   input  wire  [clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0]  divout,
   input  wire  [clkgen_pkg::NOUT*clkgen_pkg::DIVW-1:0]  phase,
   // lock
   output logic                                          freqlock,
   output logic                                          phaselock
);

   logic                                refclk;     // selected reference
   logic                                lock_clr;
   logic [clkgen_pkg::NIN-1:0]          clksel_q;   // select seen by counter
   logic [clkgen_pkg::LOCK_CNTW-1:0]    edge_cnt;

   // dividers and phase are stored upstream but have no effect here,
   // so fout equals fref on every output
   logic unused_cfg;
   assign unused_cfg = ^{clkfbin, divin, divfb, divfrac, divout, phase};

   //##################################################
   // clock paths, all combinational
   //##################################################
   assign refclk   = |(clkin & clksel);
   assign clkvco   = refclk & en & ~reset;  // n/m = 1
   assign clkfbout = clkvco;

   for (genvar i = 0; i < clkgen_pkg::NOUT; i++) begin : gen_out
      assign clkout[i] = bypass ? refclk : clkvco;
   end

   //##################################################
   // lock model
   //##################################################
   // select change is seen until the new ref clock ticks once
   always_ff @(posedge refclk) begin
      clksel_q <= clksel;
   end

   assign lock_clr = ~en | reset | (clksel != clksel_q);

   always_ff @(posedge refclk) begin
      if (lock_clr)
         edge_cnt <= '0;
      else if (edge_cnt != clkgen_pkg::PHASE_CNT)
         edge_cnt <= edge_cnt + 1'b1;  // saturate at phase lock
   end

   // flags drop at once on clear, no wait for an edge
   assign freqlock  = ~lock_clr & (edge_cnt >= clkgen_pkg::FREQ_CNT);
   assign phaselock = ~lock_clr & (edge_cnt >= clkgen_pkg::PHASE_CNT);

endmodule

`default_nettype wire

/* list.f */
hw/clkgen_pkg.sv
hw/clkgen_regs.sv
hw/la_pll.sv
hw/clkgen_lock_mon.sv
hw/clkgen_top.sv
tests/clkgen_chk.sv
tests/clkgen_tb.sv

/* run.sh */
#!/bin/sh
# build and run the clkgen testbench with verilator, result taken from sim.log
rm -f sim.log
verilator --binary --assert --top-module clkgen_tb -f list.f -o clkgen_sim \
   && ./obj_dir/clkgen_sim > sim.log 2>&1 \
   || echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0

/* tests/clkgen_chk.sv */
// concurrent checks for the clock generator, bound into clkgen_top
// reset state, bypass path, output reset timing, sticky lost lock
`timescale 1ns/100ps
`default_nettype none

module clkgen_chk (
   input wire                          clk,
   input wire                          reset,
   input wire [clkgen_pkg::NIN-1:0]    clkin,
   input wire [clkgen_pkg::NOUT-1:0]   clkout,
   input wire                          clkvco,
   input wire                          out_reset,
   input wire [clkgen_pkg::DATAW-1:0]  rdata,
   input wire                          en,
   input wire                          bypass,
   input wire [clkgen_pkg::NIN-1:0]    clksel,
   input wire                          lock_sync,
   input wire                          lock_lost,
   input wire                          clr_lost
);

   logic [clkgen_pkg::RST_HOLD:0]  lock_hist;  // past lock_sync, bit 0 newest
   logic                           ref_sel;

   assign ref_sel = clksel[1] ? clkin[1] : clkin[0];  // one hot select

   always_ff @(posedge clk) begin
      if (reset)
         lock_hist <= '0;
      else
         lock_hist <= {lock_hist[clkgen_pkg::RST_HOLD-1:0], lock_sync};
   end

   // ##################################################
   // idle and bypass
   // ##################################################
   a_reset_state: assert property (@(posedge clk)
      reset |=> (!lock_sync && !lock_lost && out_reset && !clkvco
                 && clkout == '0 && rdata == '0))
      else $error("outputs not idle after reset");

   a_disabled_low: assert property (@(posedge clk) disable iff (reset)
      (!en && !bypass) |-> (clkout == '0 && !clkvco))
      else $error("clock toggles while disabled without bypass");

   a_bypass: assert property (@(posedge clk) disable iff (reset)
      bypass |-> (clkout == {clkgen_pkg::NOUT{ref_sel}}))
      else $error("bypass output differs from selected reference");

   a_vco: assert property (@(posedge clk) disable iff (reset)
      en |-> (clkvco == ref_sel))
      else $error("clkvco differs from selected reference while enabled");

   a_pll_path: assert property (@(posedge clk) disable iff (reset)
      (en && !bypass) |-> (clkout == {clkgen_pkg::NOUT{ref_sel}}))
      else $error("output differs from selected reference while enabled");

   // ##################################################
   // output reset and lost lock
   // ##################################################
   a_rst_release: assert property (@(posedge clk) disable iff (reset)
      (&lock_hist[clkgen_pkg::RST_HOLD-1:0]) |-> !out_reset)
      else $error("out_reset still high after stable lock");

   a_rst_exact: assert property (@(posedge clk) disable iff (reset)
      $fell(out_reset) |->
         ((&lock_hist[clkgen_pkg::RST_HOLD-1:0]) && !lock_hist[clkgen_pkg::RST_HOLD]))
      else $error("out_reset released at the wrong cycle");

   a_rst_on_loss: assert property (@(posedge clk) disable iff (reset)
      !lock_hist[0] |-> out_reset)
      else $error("out_reset low without lock");

   a_lost_set: assert property (@(posedge clk) disable iff (reset)
      ($fell(lock_sync) && en) |=> lock_lost)
      else $error("lock loss not flagged");

   a_lost_sticky: assert property (@(posedge clk) disable iff (reset)
      (lock_lost && en && !clr_lost) |=> lock_lost)
      else $error("lost lock flag cleared without a status write");

endmodule

bind clkgen_top clkgen_chk u_chk (
   .clk       (clk),
   .reset     (reset),
   .clkin     (clkin),
   .clkout    (clkout),
   .clkvco    (clkvco),
   .out_reset (out_reset),
   .rdata     (rdata),
   .en        (en),
   .bypass    (bypass),
   .clksel    (clksel),
   .lock_sync (lock_sync),
   .lock_lost (lock_lost),
   .clr_lost  (clr_lost)
);

`default_nettype wire

/* tests/clkgen_tb.sv */
// testbench for the clock generator
// clocks, reset, register traffic, lock waits and the run result
`timescale 1ns/100ps
`default_nettype none

module clkgen_tb;

   logic                              clk;
   logic                              reset;
   logic                              ref0;
   logic                              ref1;
   logic [clkgen_pkg::NIN-1:0]        clkin;
   logic                              wr;
   logic                              rd;
   logic [clkgen_pkg::ADDRW-1:0]      addr;
   logic [clkgen_pkg::DATAW-1:0]      wdata;
   logic [clkgen_pkg::DATAW-1:0]      rdata;
   logic [clkgen_pkg::NOUT-1:0]       clkout;
   logic                              clkvco;
   logic                              out_reset;

   clkgen_pkg::cfg_word_u             cfg;         // write data composer
   logic [clkgen_pkg::DATAW-1:0]      exp_div;     // shadow copies
   logic [clkgen_pkg::DATAW-1:0]      exp_divout;
   logic [clkgen_pkg::DATAW-1:0]      exp_phase;

   always #50 clk = ~clk;   // control clock, 100 ns
   always #15 ref0 = ~ref0; // reference 0, 30 ns
   always #35 ref1 = ~ref1; // reference 1, 70 ns

   assign clkin = {ref1, ref0};

   clkgen_top u_dut (
      .clk       (clk),
      .reset     (reset),
      .clkin     (clkin),
      .wr        (wr),
      .rd        (rd),
      .addr      (addr),
      .wdata     (wdata),
      .rdata     (rdata),
      .clkout    (clkout),
      .clkvco    (clkvco),
      .out_reset (out_reset)
   );

   // ##################################################
   // helpers
   // ##################################################
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic write_reg(input logic [clkgen_pkg::ADDRW-1:0] a,
                            input logic [clkgen_pkg::DATAW-1:0] d);
      @(posedge clk);
      wr    <= 1'b1;
      addr  <= a;
      wdata <= d;
      @(posedge clk);
      wr    <= 1'b0;   // single cycle strobe
   endtask

   task automatic read_reg(input logic [clkgen_pkg::ADDRW-1:0] a,
                           output logic [clkgen_pkg::DATAW-1:0] d);
      @(posedge clk);
      rd   <= 1'b1;
      addr <= a;
      @(posedge clk);
      rd   <= 1'b0;
      @(negedge clk);  // rdata settled mid cycle
      d = rdata;
   endtask

   task automatic check_reg(input logic [clkgen_pkg::ADDRW-1:0] a,
                            input logic [clkgen_pkg::DATAW-1:0] exp,
                            input string name);
      logic [clkgen_pkg::DATAW-1:0] got;
      read_reg(a, got);
      if (got !== exp) begin
         stop_run($sformatf("ERROR at %0t: rdata of %s is 0x%08h, expected 0x%08h",
                            $time, name, got, exp));
      end
   endtask

   function automatic logic [clkgen_pkg::DATAW-1:0] ctrl_word(input logic e, input logic b,
                                                            input logic [1:0] s);
      clkgen_pkg::cfg_word_u w;
      w             = '0;
      w.ctrl.en     = e;
      w.ctrl.bypass = b;
      w.ctrl.clksel = s;
      return w;
   endfunction

   // write ctrl, read back with non one-hot select mapped to input 0
   task automatic write_ctrl(input logic e, input logic b, input logic [1:0] s);
      logic [1:0] s_exp;
      s_exp = (s == 2'b01 || s == 2'b10) ? s : 2'b01;
      write_reg(clkgen_pkg::ADDR_CTRL, ctrl_word(e, b, s));
      check_reg(clkgen_pkg::ADDR_CTRL, ctrl_word(e, b, s_exp), "ctrl");
   endtask

   task automatic poll_status(input int idx, input logic val, input int max_reads);
      logic [clkgen_pkg::DATAW-1:0] st;
      int n;
      n = 0;
      read_reg(clkgen_pkg::ADDR_STATUS, st);
      while (st[idx] !== val) begin
         n++;
         if (n >= max_reads) begin
            stop_run($sformatf("timeout, status bit %0d never became %0b", idx, val));
         end
         read_reg(clkgen_pkg::ADDR_STATUS, st);
      end
   endtask

   task automatic wait_out_reset_low(input int max_cycles);
      int n;
      n = 0;
      @(negedge clk);
      while (out_reset !== 1'b0) begin
         n++;
         if (n >= max_cycles) begin
            stop_run("timeout, out_reset was never released after lock");
         end
         @(negedge clk);
      end
   endtask

   // ##################################################
   // stimulus
   // ##################################################
   initial begin
      clk   = 1'b0;
      ref0  = 1'b0;
      ref1  = 1'b0;
      reset = 1'b1;
      wr    = 1'b0;
      rd    = 1'b0;
      addr  = '0;
      wdata = '0;
      void'($urandom(73644));
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      check_reg(3'd5, '0, "unmapped address");

      for (int i = 0; i < 4; i++) begin
         cfg             = '0;
         cfg.div.divin   = 8'($urandom());
         cfg.div.divfb   = 8'($urandom());
         cfg.div.divfrac = 8'($urandom());
         exp_div         = cfg;
         exp_divout      = $urandom() & 32'h0000_ffff;  // two 8 bit fields
         exp_phase       = $urandom() & 32'h0000_ffff;
         write_reg(clkgen_pkg::ADDR_DIV, exp_div);
         write_reg(clkgen_pkg::ADDR_DIVOUT, exp_divout);
         write_reg(clkgen_pkg::ADDR_PHASE, exp_phase);
         check_reg(clkgen_pkg::ADDR_DIV, exp_div, "div");
         check_reg(clkgen_pkg::ADDR_DIVOUT, exp_divout, "divout");
         check_reg(clkgen_pkg::ADDR_PHASE, exp_phase, "phase");
      end

      // bypass on each input with the pll disabled
      write_ctrl(1'b0, 1'b1, 2'b10);
      repeat (8) @(posedge clk);
      write_ctrl(1'b0, 1'b1, 2'b01);
      repeat (8) @(posedge clk);
      write_ctrl(1'b1, 1'b1, 2'b10);  // bypass with the pll enabled, too short to lock
      repeat (8) @(posedge clk);
      write_ctrl(1'b0, 1'b0, 2'b11);  // coerced select
      write_ctrl(1'b0, 1'b0, 2'b00);

      // lock on input 0 and release of the output reset
      write_ctrl(1'b1, 1'b0, 2'b01);
      check_reg(clkgen_pkg::ADDR_STATUS, 32'h0, "status before lock");
      poll_status(0, 1'b1, 60);
      wait_out_reset_low(20);
      check_reg(clkgen_pkg::ADDR_STATUS, 32'h1, "status locked");

      // select change while enabled drops lock
      write_ctrl(1'b1, 1'b0, 2'b10);
      poll_status(0, 1'b0, 20);
      check_reg(clkgen_pkg::ADDR_STATUS, 32'h2, "status after loss");
      poll_status(0, 1'b1, 60);
      check_reg(clkgen_pkg::ADDR_STATUS, 32'h3, "status after relock");  // lost is sticky
      write_reg(clkgen_pkg::ADDR_STATUS, '0);
      check_reg(clkgen_pkg::ADDR_STATUS, 32'h1, "status after clear");

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire
